//--- hdl/dial_pkg.sv
package dial_pkg;

    // ------------------------------------------------------------
    // Scan chain geometry and instruction codes
    // ------------------------------------------------------------
    localparam int ir_width = 4;
    localparam int dr_width = 16;

    localparam logic [ir_width-1:0] user4_instr      = 4'b0100;
    localparam logic [ir_width-1:0] ir_capture_value = 4'b0001; // Fixed pattern per 1149.1.

    localparam logic [7:0] write_ascii_byte_cmd = 8'hA0;

    // ------------------------------------------------------------
    // Text characters understood by the line parser
    // ------------------------------------------------------------
    localparam logic [7:0] ascii_newline = 8'h0A;
    localparam logic [7:0] ascii_zero    = 8'h30;
    localparam logic [7:0] ascii_nine    = 8'h39;
    localparam logic [7:0] ascii_left    = 8'h4C;
    localparam logic [7:0] ascii_right   = 8'h52;

    localparam logic [3:0] dial_start_tens  = 4'd5;
    localparam logic [3:0] dial_start_units = 4'd0;

    typedef struct packed {
        logic [7:0] cmd;
        logic [7:0] data;
    } tap_data_t;

    typedef struct packed {
        logic run_test_idle;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic user4_selected;
    } tap_state_t;

    typedef struct packed {
        logic [3:0] tens;
        logic [3:0] units;
    } bcd_steps_t;

    typedef struct packed {
        logic [7:0] tens_char;
        logic [7:0] units_char;
    } dial_ascii_t;

endpackage

//--- hdl/tap_controller.sv
`timescale 1ns/1ps

module tap_controller import dial_pkg::*; (
    input  logic       tck,
    input  logic       tms,
    input  logic       tdi,
    output logic       state_is_test_logic_reset,
    output tap_state_t tap_state,
    output logic       ir_tdo
);

    typedef enum logic [3:0] {
        st_test_logic_reset,
        st_run_test_idle,
        st_select_dr_scan,
        st_capture_dr,
        st_shift_dr,
        st_exit1_dr,
        st_pause_dr,
        st_exit2_dr,
        st_update_dr,
        st_select_ir_scan,
        st_capture_ir,
        st_shift_ir,
        st_exit1_ir,
        st_pause_ir,
        st_exit2_ir,
        st_update_ir
    } tap_fsm_t;

    tap_fsm_t state, state_next;
    logic [ir_width-1:0] ir_shift;
    logic [ir_width-1:0] ir_active;
    logic bypass_reg;

    // ------------------------------------------------------------
    // TAP state machine
    // ------------------------------------------------------------
    always_comb begin
        case (state)
            st_test_logic_reset: state_next = tms ? st_test_logic_reset : st_run_test_idle;
            st_run_test_idle:    state_next = tms ? st_select_dr_scan : st_run_test_idle;
            st_select_dr_scan:   state_next = tms ? st_select_ir_scan : st_capture_dr;
            st_capture_dr:       state_next = tms ? st_exit1_dr : st_shift_dr;
            st_shift_dr:         state_next = tms ? st_exit1_dr : st_shift_dr;
            st_exit1_dr:         state_next = tms ? st_update_dr : st_pause_dr;
            st_pause_dr:         state_next = tms ? st_exit2_dr : st_pause_dr;
            st_exit2_dr:         state_next = tms ? st_update_dr : st_shift_dr;
            st_update_dr:        state_next = tms ? st_select_dr_scan : st_run_test_idle;
            st_select_ir_scan:   state_next = tms ? st_test_logic_reset : st_capture_ir;
            st_capture_ir:       state_next = tms ? st_exit1_ir : st_shift_ir;
            st_shift_ir:         state_next = tms ? st_exit1_ir : st_shift_ir;
            st_exit1_ir:         state_next = tms ? st_update_ir : st_pause_ir;
            st_pause_ir:         state_next = tms ? st_exit2_ir : st_pause_ir;
            st_exit2_ir:         state_next = tms ? st_update_ir : st_shift_ir;
            st_update_ir:        state_next = tms ? st_select_dr_scan : st_run_test_idle;
            default:             state_next = st_test_logic_reset; // Recovers from power-up.
        endcase
    end

    always_ff @(posedge tck) begin
        state <= state_next; // Five tms-high edges reach reset from anywhere.
    end

    // ------------------------------------------------------------
    // Instruction and bypass registers
    // ------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (state == st_capture_ir) begin
            ir_shift <= ir_capture_value;
        end else if (state == st_shift_ir) begin
            ir_shift <= {tdi, ir_shift[ir_width-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (state_is_test_logic_reset) begin
            ir_active <= user4_instr;
        end else if (state == st_update_ir) begin
            ir_active <= ir_shift;
        end
    end

    always_ff @(posedge tck) begin
        if (state == st_capture_dr) begin
            bypass_reg <= 1'b0;
        end else if (state == st_shift_dr) begin
            bypass_reg <= tdi; // One bit of delay through the chain.
        end
    end

    assign state_is_test_logic_reset = (state == st_test_logic_reset);

    assign tap_state.run_test_idle  = (state == st_run_test_idle);
    assign tap_state.capture_dr     = (state == st_capture_dr);
    assign tap_state.shift_dr       = (state == st_shift_dr);
    assign tap_state.update_dr      = (state == st_update_dr);
    assign tap_state.user4_selected = (ir_active == user4_instr);

    assign ir_tdo = (state == st_shift_ir) ? ir_shift[0] : bypass_reg;

    five_tms_reach_reset: assert property (
        @(posedge tck)
        (tms && $past(tms) && $past(tms, 2) && $past(tms, 3) && $past(tms, 4))
            |=> state_is_test_logic_reset
    );

endmodule

//--- hdl/user_register.sv
`timescale 1ns/1ps

module user_register import dial_pkg::*; (
    input  logic        tck,
    input  logic        state_is_test_logic_reset,
    input  tap_state_t  tap_state,
    input  logic        tdi,
    input  dial_ascii_t position,
    output logic        dr_tdo,
    output logic [7:0]  ascii_byte,
    output logic        write_ascii_byte
);

    tap_data_t tap_data;
    logic [dr_width-1:0] readback;
    logic tap_valid;

    // ------------------------------------------------------------
    // Scan path
    // ------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (tap_state.user4_selected && tap_state.shift_dr) begin
            tap_data <= {tdi, tap_data[dr_width-1:1]}; // LSB arrives first.
        end
    end

    always_ff @(posedge tck) begin
        if (tap_state.user4_selected) begin
            if (tap_state.capture_dr) begin
                readback <= position;
            end else if (tap_state.shift_dr) begin
                readback <= {1'b1, readback[dr_width-1:1]}; // Pads with ones past the word.
            end
        end
    end

    assign dr_tdo = readback[0];

    // ------------------------------------------------------------
    // Command decode
    // ------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (state_is_test_logic_reset) begin
            tap_valid        <= 1'b0;
            write_ascii_byte <= 1'b0;
        end else begin
            tap_valid        <= tap_state.user4_selected && tap_state.update_dr;
            write_ascii_byte <= tap_valid && (tap_data.cmd == write_ascii_byte_cmd);
        end
    end

    always_ff @(posedge tck) begin
        if (tap_valid) begin
            ascii_byte <= tap_data.data; // Held so a new scan cannot disturb it.
        end
    end

endmodule

//--- hdl/ascii_decoder.sv
`timescale 1ns/1ps

module ascii_decoder import dial_pkg::*; (
    input  logic       tck,
    input  logic       state_is_test_logic_reset,
    input  logic [7:0] ascii_byte,
    input  logic       write_ascii_byte,
    output bcd_steps_t right_steps,
    output logic       steps_valid
);

    logic dir_left;
    bcd_steps_t count;
    logic is_digit;

    // Ten's complement modulo 100, digit by digit.
    function automatic bcd_steps_t tens_complement(input bcd_steps_t value);
        bcd_steps_t result;
        if (value.units == 4'd0) begin
            result.units = 4'd0;
            result.tens  = (value.tens == 4'd0) ? 4'd0 : 4'd10 - value.tens;
        end else begin
            result.units = 4'd10 - value.units;
            result.tens  = 4'd9 - value.tens; // Borrow taken by the units digit.
        end
        return result;
    endfunction

    assign is_digit = (ascii_byte >= ascii_zero) && (ascii_byte <= ascii_nine);

    // ------------------------------------------------------------
    // Line parser
    // ------------------------------------------------------------
    always_ff @(posedge tck) begin
        if (state_is_test_logic_reset) begin
            dir_left    <= 1'b0;
            count       <= '0;
            steps_valid <= 1'b0;
        end else begin
            steps_valid <= 1'b0;
            if (write_ascii_byte) begin
                if (ascii_byte == ascii_left) begin
                    dir_left <= 1'b1;
                    count    <= '0;
                end else if (ascii_byte == ascii_right) begin
                    dir_left <= 1'b0;
                    count    <= '0;
                end else if (is_digit) begin
                    count.tens  <= count.units; // Older digits fall off the top.
                    count.units <= ascii_byte[3:0];
                end else if (ascii_byte == ascii_newline) begin
                    steps_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge tck) begin
        if (write_ascii_byte && (ascii_byte == ascii_newline)) begin
            right_steps <= dir_left ? tens_complement(count) : count;
        end
    end

    count_digits_decimal: assert property (
        @(posedge tck) disable iff (state_is_test_logic_reset)
        (count.tens <= 4'd9) && (count.units <= 4'd9)
    );

endmodule

//--- hdl/bcd_dial.sv
`timescale 1ns/1ps

module bcd_dial import dial_pkg::*; (
    input  logic        tck,
    input  logic        state_is_test_logic_reset,
    input  bcd_steps_t  right_steps,
    input  logic        steps_valid,
    output dial_ascii_t position
);

    logic [3:0] tens;
    logic [3:0] units;
    logic [4:0] units_sum;
    logic [4:0] tens_sum;
    logic units_carry;

    // ------------------------------------------------------------
    // Decimal adder
    // ------------------------------------------------------------
    always_comb begin
        units_sum   = {1'b0, units} + {1'b0, right_steps.units};
        units_carry = (units_sum > 5'd9);
        tens_sum    = {1'b0, tens} + {1'b0, right_steps.tens} + {4'd0, units_carry};
    end

    always_ff @(posedge tck) begin
        if (state_is_test_logic_reset) begin
            tens  <= dial_start_tens;
            units <= dial_start_units;
        end else if (steps_valid) begin
            if (units_carry) begin
                units <= 4'(units_sum - 5'd10);
            end else begin
                units <= units_sum[3:0];
            end
            if (tens_sum > 5'd9) begin
                tens <= 4'(tens_sum - 5'd10); // Hundreds carry is dropped.
            end else begin
                tens <= tens_sum[3:0];
            end
        end
    end

    assign position.tens_char  = ascii_zero + {4'd0, tens};
    assign position.units_char = ascii_zero + {4'd0, units};

    dial_digits_decimal: assert property (
        @(posedge tck) disable iff (state_is_test_logic_reset)
        (tens <= 4'd9) && (units <= 4'd9)
    );

endmodule

//--- hdl/jtag_dial_top.sv
`timescale 1ns/1ps

module jtag_dial_top import dial_pkg::*; (
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    output logic tdo
);

    logic        state_is_test_logic_reset;
    tap_state_t  tap_state;
    logic        ir_tdo;
    logic        dr_tdo;
    logic [7:0]  ascii_byte;
    logic        write_ascii_byte;
    bcd_steps_t  right_steps;
    logic        steps_valid;
    dial_ascii_t position;

    tap_controller tap_controller_i (
        .tck                       (tck),
        .tms                       (tms),
        .tdi                       (tdi),
        .state_is_test_logic_reset (state_is_test_logic_reset),
        .tap_state                 (tap_state),
        .ir_tdo                    (ir_tdo)
    );

    user_register user_register_i (
        .tck                       (tck),
        .state_is_test_logic_reset (state_is_test_logic_reset),
        .tap_state                 (tap_state),
        .tdi                       (tdi),
        .position                  (position),
        .dr_tdo                    (dr_tdo),
        .ascii_byte                (ascii_byte),
        .write_ascii_byte          (write_ascii_byte)
    );

    ascii_decoder ascii_decoder_i (
        .tck                       (tck),
        .state_is_test_logic_reset (state_is_test_logic_reset),
        .ascii_byte                (ascii_byte),
        .write_ascii_byte          (write_ascii_byte),
        .right_steps               (right_steps),
        .steps_valid               (steps_valid)
    );

    bcd_dial bcd_dial_i (
        .tck                       (tck),
        .state_is_test_logic_reset (state_is_test_logic_reset),
        .right_steps               (right_steps),
        .steps_valid               (steps_valid),
        .position                  (position)
    );

    // User register drives the pin only while it is shifting.
    assign tdo = (tap_state.user4_selected && tap_state.shift_dr) ? dr_tdo : ir_tdo;

endmodule

//--- bench/jtag_dial_tb.sv
`timescale 1ns/1ps

module jtag_dial_tb import dial_pkg::*;;

    localparam int num_rows   = 10;
    localparam int clk_period = 20;

    typedef struct packed {
        logic [7:0]  dir;
        logic [9:0]  steps;
        dial_ascii_t expected;
    } row_t;

    // Each expected position follows from the one in the row above, starting at 50.
    row_t rows [num_rows] = '{
        '{"R", 10'd48,  "98"},
        '{"R", 10'd5,   "03"},
        '{"R", 10'd47,  "50"},
        '{"L", 10'd68,  "82"},
        '{"L", 10'd0,   "82"},
        '{"L", 10'd150, "32"},
        '{"R", 10'd999, "31"},
        '{"L", 10'd7,   "24"},
        '{"R", 10'd100, "24"},
        '{"L", 10'd999, "25"}
    };

    logic tck;
    logic tms;
    logic tdi;
    logic tdo;

    jtag_dial_top uut (
        .tck (tck),
        .tms (tms),
        .tdi (tdi),
        .tdo (tdo)
    );

    initial begin
        tck = 1'b0;
        forever #(clk_period / 2) tck = ~tck;
    end

    initial begin
        #(num_rows * 40 * 30 * clk_period);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired before the test sequence finished");
    end

    // ------------------------------------------------------------
    // JTAG pin sequencing
    // ------------------------------------------------------------
    task automatic step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tms = tms_v;
        tdi = tdi_v;
        @(negedge tck);
        tdo_v = tdo; // Sampled half a period before the shift edge.
        @(posedge tck);
        #2;
    endtask

    task automatic scan_ir(input logic [ir_width-1:0] instr, output logic [ir_width-1:0] captured);
        logic tdo_bit;
        step(1'b1, 1'b0, tdo_bit);
        step(1'b1, 1'b0, tdo_bit);
        step(1'b0, 1'b0, tdo_bit);
        step(1'b0, 1'b0, tdo_bit);
        for (int i = 0; i < ir_width; i++) begin
            step(i == ir_width - 1, instr[i], captured[i]);
        end
        step(1'b1, 1'b0, tdo_bit);
        step(1'b0, 1'b0, tdo_bit);
    endtask

    task automatic scan_dr(input logic [dr_width-1:0] word, output logic [dr_width-1:0] captured);
        logic tdo_bit;
        step(1'b1, 1'b0, tdo_bit);
        step(1'b0, 1'b0, tdo_bit);
        step(1'b0, 1'b0, tdo_bit);
        for (int i = 0; i < dr_width; i++) begin
            step(i == dr_width - 1, word[i], captured[i]);
        end
        step(1'b1, 1'b0, tdo_bit);
        step(1'b0, 1'b0, tdo_bit);
        // Extra Run-Test/Idle cycles so the dial settles before the next capture.
        repeat (2) step(1'b0, 1'b0, tdo_bit);
    endtask

    task automatic send_char(input logic [7:0] c);
        tap_data_t word;
        logic [dr_width-1:0] captured;
        word.cmd  = write_ascii_byte_cmd;
        word.data = c;
        scan_dr(word, captured);
    endtask

    task automatic read_position(output dial_ascii_t pos);
        logic [dr_width-1:0] captured;
        scan_dr('0, captured);
        pos = captured;
    endtask

    task automatic send_line(input logic [7:0] dir, input logic [9:0] steps);
        string digits;
        digits = $sformatf("%0d", steps);
        send_char(dir);
        for (int k = 0; k < digits.len(); k++) begin
            send_char(digits[k]);
        end
        send_char(ascii_newline);
    endtask

    task automatic send_filler();
        int count;
        logic [7:0] filler;
        tap_data_t word;
        logic [dr_width-1:0] captured;
        count = 1 + int'($urandom % 3);
        repeat (count) begin
            filler = 8'h61 + 8'($urandom % 26); // Lower case letters carry no meaning.
            send_char(filler);
        end
        word.cmd  = 8'h5A; // A newline under a foreign command must not repeat the line.
        word.data = ascii_newline;
        scan_dr(word, captured);
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic check_position(input string name, input dial_ascii_t expected,
                                  input dial_ascii_t actual);
        if (actual !== expected) begin
            $display("error %s: expected \"%s\" actual \"%s\" (%h)", name, expected, actual,
                     actual);
            $display("Simulation failed");
            $fatal(1, "Dial position mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [dr_width-1:0] expected,
                              input logic [dr_width-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Scanned word mismatch");
        end
    endtask

    task automatic check_ir(input string name, input logic [ir_width-1:0] expected,
                            input logic [ir_width-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %b actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Instruction register capture mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic tdo_bit;
        dial_ascii_t pos;
        logic [dr_width-1:0] word;
        logic [dr_width-1:0] captured;
        logic [ir_width-1:0] ir_captured;
        tms = 1'b1;
        tdi = 1'b0;
        void'($urandom(32'h6637_09ff));
        repeat (9) @(posedge tck); // Five edges reach Test-Logic-Reset, four more hold it.
        #2;
        step(1'b0, 1'b0, tdo_bit);

        read_position(pos);
        check_position("after reset", "50", pos);
        scan_ir(user4_instr, ir_captured);
        check_ir("ir capture", ir_capture_value, ir_captured);

        for (int i = 0; i < num_rows; i++) begin
            send_line(rows[i].dir, rows[i].steps);
            read_position(pos);
            check_position($sformatf("row %0d %c%0d", i, rows[i].dir, rows[i].steps),
                           rows[i].expected, pos);
            send_filler();
            read_position(pos);
            check_position($sformatf("row %0d filler", i), rows[i].expected, pos);
        end

        scan_ir(4'b1111, ir_captured);
        check_ir("bypass ir capture", ir_capture_value, ir_captured);
        word = 16'($urandom);
        scan_dr(word, captured);
        check_word("bypass delay", {word[dr_width-2:0], 1'b0}, captured);
        send_line("R", 10'd37); // Lost while the user register is not selected.
        scan_ir(user4_instr, ir_captured);
        read_position(pos);
        check_position("after bypass", rows[num_rows-1].expected, pos);

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- src.f
hdl/dial_pkg.sv
hdl/tap_controller.sv
hdl/user_register.sv
hdl/ascii_decoder.sv
hdl/bcd_dial.sv
hdl/jtag_dial_top.sv
bench/jtag_dial_tb.sv

//--- Makefile
TOP := jtag_dial_tb
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
